// ==== project.f ====
+incdir+hdl
hdl/aes_package.sv
hdl/aes_regfile.sv
hdl/aes_source.sv
hdl/aes_sink.sv
hdl/aes_engine.sv
hdl/aes_fsm.sv
hdl/aes_top.sv
verif/aes_tb.sv

// ==== verif/aes_input.txt ====
# key plaintext ciphertext stall, blocks in hex with word 3 first and word 0 last
# stall 1 randomizes the memory read and write grants
00000000000000000000000000000000 00000000000000000000000000000000 00000000000000000000000000000000 0
00000000000000000000000000000001 00000000000000000000000000000000 00000000000101000000000001000001 0
00000000000000000000000000000000 76543210fedcba9889abcdef01234567 76543210fedcba9889abcdef01234567 0
0f0e0d0c0b0a09080706050403020100 00000000000000000000000000000000 00040804000c080c00040804000c080c 0
0f0e0d0c0b0a09080706050403020100 76543210fedcba9889abcdef01234567 76503a14fed0b29489afc5eb012f4d6b 0
3c000000000000000000a50000000000 a5a5a5a512345678cafef00ddeadbeef a5a599a58b34f3ddca5bf00dde91bed3 0
00000000000000000000000000000001 00000000000000000000000000000000 00000000000101000000000001000001 1
0f0e0d0c0b0a09080706050403020100 76543210fedcba9889abcdef01234567 76503a14fed0b29489afc5eb012f4d6b 1
3c000000000000000000a50000000000 a5a5a5a512345678cafef00ddeadbeef a5a599a58b34f3ddca5bf00dde91bed3 1
00000000000000000000000000000000 76543210fedcba9889abcdef01234567 76543210fedcba9889abcdef01234567 1

// ==== verif/aes_tb.sv ====
`default_nettype none

`include "aes_params.svh"

module aes_tb;

  localparam int MEM_WORDS         = 1024;
  localparam int MAX_VECTORS       = 128;
  localparam int CYCLES_PER_VECTOR = 400;
  localparam logic [`AES_DATA_W-1:0] STATUS_BUSY = 32'h1;
  localparam logic [`AES_DATA_W-1:0] STATUS_DONE = 32'h2;
  localparam logic [1:0]             RESP_OKAY   = 2'b00;

  logic                   clk;
  logic                   reset_n;
  logic [`AES_ADDR_W-1:0] awaddr_i;
  logic                   awvalid_i;
  logic                   awready_o;
  logic [`AES_DATA_W-1:0] wdata_i;
  logic [3:0]             wstrb_i;
  logic                   wvalid_i;
  logic                   wready_o;
  logic [1:0]             bresp_o;
  logic                   bvalid_o;
  logic                   bready_i;
  logic [`AES_ADDR_W-1:0] araddr_i;
  logic                   arvalid_i;
  logic                   arready_o;
  logic [`AES_DATA_W-1:0] rdata_o;
  logic [1:0]             rresp_o;
  logic                   rvalid_o;
  logic                   rready_i;
  logic                   rd_req_o;
  logic [`AES_ADDR_W-1:0] rd_addr_o;
  logic                   rd_gnt_i;
  logic [`AES_DATA_W-1:0] rd_data_i;
  logic                   rd_valid_i;
  logic                   wr_req_o;
  logic [`AES_ADDR_W-1:0] wr_addr_o;
  logic [`AES_DATA_W-1:0] wr_data_o;
  logic                   wr_gnt_i;

  logic [`AES_DATA_W-1:0]  mem [MEM_WORDS];
  aes_package::aes_block_t key_q [$];
  aes_package::aes_block_t pt_q [$];
  aes_package::aes_block_t ct_q [$];
  bit                      stall_q [$];
  int                      vec_count;
  bit                      vectors_ready;
  bit                      stall;
  int                      write_count;
  logic [`AES_ADDR_W-1:0]  dst_base;

  aes_top uut (.*);

  always #4 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [`AES_DATA_W-1:0] expected,
                            input logic [`AES_DATA_W-1:0] actual);
    if (actual !== expected) begin
      report_error($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, expected,
                             actual));
    end
  endtask

  task automatic check_block(input string name, input aes_package::aes_block_t expected,
                             input aes_package::aes_block_t actual);
    if (actual !== expected) begin
      report_error($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, expected,
                             actual));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
    if (actual !== expected) begin
      report_error($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, expected,
                             actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_error($sformatf("[FAIL] t=%0t %s expected %b got %b", $time, name, expected,
                             actual));
    end
  endtask

  function automatic logic [`AES_ADDR_W-1:0] reg_addr(input aes_package::aes_reg_idx_t idx);
    return `AES_ADDR_W'({idx, 2'b00});
  endfunction

  function automatic int word_index(input logic [`AES_ADDR_W-1:0] addr);
    return int'(addr[11:2]);
  endfunction

  // Every word differs, so a missed write stays visible
  function automatic logic [`AES_DATA_W-1:0] fill_word(input int idx);
    return 32'h5a5a0000 ^ `AES_DATA_W'(idx * 4);
  endfunction

  function automatic bit grant_allowed();
    if (!stall) begin
      return 1'b1;
    end
    return ($urandom % 2) == 0;
  endfunction

  task automatic write_register(input logic [`AES_ADDR_W-1:0] addr,
                                input logic [`AES_DATA_W-1:0] data);
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wstrb_i   = 4'hf;
    wvalid_i  = 1'b1;
    bready_i  = 1'b1;
    do begin
      @(negedge clk);
    end while (!awready_o);
    // AW and W are taken in the same cycle
    check_flag("wready_o", 1'b1, wready_o);
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    while (!bvalid_o) begin
      @(negedge clk);
    end
    check_resp("bresp_o", RESP_OKAY, bresp_o);
    @(negedge clk);
    bready_i = 1'b0;
  endtask

  task automatic read_register(input logic [`AES_ADDR_W-1:0] addr,
                               output logic [`AES_DATA_W-1:0] data);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    rready_i  = 1'b1;
    do begin
      @(negedge clk);
    end while (!arready_o);
    @(negedge clk);
    arvalid_i = 1'b0;
    while (!rvalid_o) begin
      @(negedge clk);
    end
    check_resp("rresp_o", RESP_OKAY, rresp_o);
    data = rdata_o;
    @(negedge clk);
    rready_i = 1'b0;
  endtask

  // Memory model, grants and data change on the falling edge
  initial begin : memory_model
    logic                   rd_granted;
    logic [`AES_ADDR_W-1:0] rd_addr_q;
    rd_gnt_i   = 1'b0;
    rd_valid_i = 1'b0;
    rd_data_i  = '0;
    wr_gnt_i   = 1'b0;
    rd_granted = 1'b0;
    rd_addr_q  = '0;
    void'($urandom(18));
    forever begin
      @(negedge clk);
      // Data for the grant taken at the last rising edge
      rd_valid_i = rd_granted;
      rd_data_i  = rd_granted ? mem[word_index(rd_addr_q)] : '0;
      rd_gnt_i   = rd_req_o && grant_allowed();
      rd_granted = rd_gnt_i;
      rd_addr_q  = rd_addr_o;
      wr_gnt_i   = wr_req_o && grant_allowed();
      if (wr_gnt_i) begin
        if (wr_addr_o < dst_base || wr_addr_o >= dst_base + 16) begin
          report_error($sformatf("Write to address %h outside the destination block",
                                 wr_addr_o));
        end
        mem[word_index(wr_addr_o)] = wr_data_o;
        write_count++;
      end
    end
  end

  initial begin : watchdog
    wait (vectors_ready);
    repeat (vec_count * CYCLES_PER_VECTOR + 1000) @(posedge clk);
    report_error("The run timed out before all vectors completed");
  end

  initial begin : main_sequence
    int                      fd;
    int                      fields;
    int                      stall_v;
    string                   line;
    aes_package::aes_block_t key;
    aes_package::aes_block_t pt;
    aes_package::aes_block_t ct;
    aes_package::aes_block_t result;
    logic [`AES_ADDR_W-1:0]  src_addr;
    logic [`AES_DATA_W-1:0]  rdata;
    clk           = 1'b0;
    reset_n       = 1'b0;
    awaddr_i      = '0;
    awvalid_i     = 1'b0;
    wdata_i       = '0;
    wstrb_i       = '0;
    wvalid_i      = 1'b0;
    bready_i      = 1'b0;
    araddr_i      = '0;
    arvalid_i     = 1'b0;
    rready_i      = 1'b0;
    write_count   = 0;
    stall         = 1'b0;
    vectors_ready = 1'b0;
    dst_base      = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end

    fd = $fopen("verif/aes_input.txt", "r");
    if (fd == 0) begin
      report_error("Could not open verif/aes_input.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        fields = $sscanf(line, "%h %h %h %d", key, pt, ct, stall_v);
        if (fields != 4) begin
          report_error($sformatf("Malformed vector line: %s", line));
        end
        key_q.push_back(key);
        pt_q.push_back(pt);
        ct_q.push_back(ct);
        stall_q.push_back(stall_v != 0);
      end
    end
    $fclose(fd);
    vec_count = key_q.size();
    if (vec_count == 0 || vec_count > MAX_VECTORS) begin
      report_error($sformatf("Unusable vector count %0d in verif/aes_input.txt", vec_count));
    end
    vectors_ready = 1'b1;

    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    for (int v = 0; v < vec_count; v++) begin
      src_addr    = `AES_ADDR_W'(v * 16);
      dst_base    = `AES_ADDR_W'(32'h800 + v * 16);
      stall       = stall_q[v];
      write_count = 0;
      for (int w = 0; w < 4; w++) begin
        mem[word_index(src_addr) + w] = pt_q[v][w];
      end

      write_register(reg_addr(aes_package::REG_SRC), src_addr);
      write_register(reg_addr(aes_package::REG_DST), dst_base);
      for (int w = 0; w < 4; w++) begin
        write_register(reg_addr(aes_package::REG_KEY0) + 4 * w, key_q[v][w]);
      end
      read_register(reg_addr(aes_package::REG_SRC), rdata);
      check_word("src_addr", src_addr, rdata);
      read_register(reg_addr(aes_package::REG_DST), rdata);
      check_word("dst_addr", dst_base, rdata);
      for (int w = 0; w < 4; w++) begin
        read_register(reg_addr(aes_package::REG_KEY0) + 4 * w, rdata);
        check_word($sformatf("key%0d", w), key_q[v][w], rdata);
      end

      // Start clears done, busy shows while the job runs
      write_register(reg_addr(aes_package::REG_CTRL), 32'h1);
      read_register(reg_addr(aes_package::REG_STATUS), rdata);
      check_word("status during job", STATUS_BUSY, rdata);
      // Second start lands while busy
      write_register(reg_addr(aes_package::REG_CTRL), 32'h1);
      do begin
        read_register(reg_addr(aes_package::REG_STATUS), rdata);
      end while (rdata[0]);
      check_word("status after job", STATUS_DONE, rdata);

      // Quiet period, a stray second job would write again
      repeat (16) @(negedge clk);
      read_register(reg_addr(aes_package::REG_STATUS), rdata);
      check_word("status after quiet period", STATUS_DONE, rdata);
      check_word("write count", `AES_DATA_W'(4), `AES_DATA_W'(write_count));
      for (int w = 0; w < 4; w++) begin
        result[w] = mem[word_index(dst_base) + w];
      end
      check_block($sformatf("ciphertext of vector %0d", v), ct_q[v], result);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/aes_top.sv ====
`default_nettype none

`include "aes_params.svh"

module aes_top (
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  // AXI4-Lite slave
  input  wire logic [`AES_ADDR_W-1:0] awaddr_i,
  input  wire logic                   awvalid_i,
  output logic                        awready_o,
  input  wire logic [`AES_DATA_W-1:0] wdata_i,
  input  wire logic [3:0]             wstrb_i,
  input  wire logic                   wvalid_i,
  output logic                        wready_o,
  output logic [1:0]                  bresp_o,
  output logic                        bvalid_o,
  input  wire logic                   bready_i,
  input  wire logic [`AES_ADDR_W-1:0] araddr_i,
  input  wire logic                   arvalid_i,
  output logic                        arready_o,
  output logic [`AES_DATA_W-1:0]      rdata_o,
  output logic [1:0]                  rresp_o,
  output logic                        rvalid_o,
  input  wire logic                   rready_i,
  // Memory read port
  output logic                        rd_req_o,
  output logic [`AES_ADDR_W-1:0]      rd_addr_o,
  input  wire logic                   rd_gnt_i,
  input  wire logic [`AES_DATA_W-1:0] rd_data_i,
  input  wire logic                   rd_valid_i,
  // Memory write port
  output logic                        wr_req_o,
  output logic [`AES_ADDR_W-1:0]      wr_addr_o,
  output logic [`AES_DATA_W-1:0]      wr_data_o,
  input  wire logic                   wr_gnt_i
);

  logic                    start;
  logic                    done;
  aes_package::aes_state_t fsm_state;
  logic [`AES_ADDR_W-1:0]  src_addr;
  logic [`AES_ADDR_W-1:0]  dst_addr;
  aes_package::aes_block_t key;
  logic                    src_req_start;
  logic                    snk_req_start;
  logic                    src_ready_start;
  logic                    snk_idle;
  logic                    eng_clear;
  logic                    eng_start;
  logic                    eng_enable;
  aes_package::aes_block_t blk;
  logic                    blk_valid;
  logic                    blk_ready;
  aes_package::aes_block_t out_blk;
  logic                    out_valid;
  logic                    out_ready;

  aes_regfile i_regfile (
    .clk         (clk),
    .reset_n     (reset_n),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .done_i      (done),
    .fsm_state_i (fsm_state),
    .start_o     (start),
    .src_addr_o  (src_addr),
    .dst_addr_o  (dst_addr),
    .key_o       (key)
  );

  aes_fsm i_fsm (
    .clk               (clk),
    .reset_n           (reset_n),
    .start_i           (start),
    .src_ready_start_i (src_ready_start),
    .snk_ready_start_i (snk_idle),
    .src_req_start_o   (src_req_start),
    .snk_req_start_o   (snk_req_start),
    .eng_clear_o       (eng_clear),
    .eng_start_o       (eng_start),
    .eng_enable_o      (eng_enable),
    .done_o            (done),
    .state_o           (fsm_state)
  );

  aes_source i_source (
    .clk           (clk),
    .reset_n       (reset_n),
    .req_start_i   (src_req_start),
    .base_addr_i   (src_addr),
    .ready_start_o (src_ready_start),
    .rd_req_o      (rd_req_o),
    .rd_addr_o     (rd_addr_o),
    .rd_gnt_i      (rd_gnt_i),
    .rd_data_i     (rd_data_i),
    .rd_valid_i    (rd_valid_i),
    .blk_o         (blk),
    .blk_valid_o   (blk_valid),
    .blk_ready_i   (blk_ready)
  );

  aes_engine i_engine (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_i     (eng_clear),
    .enable_i    (eng_enable),
    .start_i     (eng_start),
    .key_i       (key),
    .blk_i       (blk),
    .blk_valid_i (blk_valid),
    .blk_ready_o (blk_ready),
    .out_o       (out_blk),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  aes_sink i_sink (
    .clk           (clk),
    .reset_n       (reset_n),
    .req_start_i   (snk_req_start),
    .base_addr_i   (dst_addr),
    .ready_start_o (snk_idle),
    .blk_i         (out_blk),
    .blk_valid_i   (out_valid),
    .blk_ready_o   (out_ready),
    .wr_req_o      (wr_req_o),
    .wr_addr_o     (wr_addr_o),
    .wr_data_o     (wr_data_o),
    .wr_gnt_i      (wr_gnt_i)
  );

endmodule

`default_nettype wire

// ==== hdl/aes_fsm.sv ====
`default_nettype none

module aes_fsm (
  input  wire logic               clk,
  input  wire logic               reset_n,
  input  wire logic               start_i,
  // Streamer handshake
  input  wire logic               src_ready_start_i,
  input  wire logic               snk_ready_start_i,
  output logic                    src_req_start_o,
  output logic                    snk_req_start_o,
  // Engine control
  output logic                    eng_clear_o,
  output logic                    eng_start_o,
  output logic                    eng_enable_o,
  // Status
  output logic                    done_o,
  output aes_package::aes_state_t state_o
);

  aes_package::aes_state_t current_state;
  aes_package::aes_state_t next_state;
  logic                    streamers_ready;

  assign streamers_ready = src_ready_start_i & snk_ready_start_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      current_state <= aes_package::AES_IDLE;
    end else begin
      current_state <= next_state;
    end
  end

  always_comb begin
    next_state = current_state;
    case (current_state)
      aes_package::AES_IDLE: begin
        if (start_i) begin
          next_state = aes_package::AES_STARTING;
        end
      end
      // Both streamers latch their addresses on this edge
      aes_package::AES_STARTING: begin
        if (streamers_ready) begin
          next_state = aes_package::AES_WORKING;
        end
      end
      // Ready again once the block is fetched and written back
      aes_package::AES_WORKING: begin
        if (streamers_ready) begin
          next_state = aes_package::AES_FINISHED;
        end
      end
      default: begin
        next_state = aes_package::AES_IDLE;
      end
    endcase
  end

  assign src_req_start_o = (current_state == aes_package::AES_STARTING);
  assign snk_req_start_o = (current_state == aes_package::AES_STARTING);
  assign eng_start_o     = (current_state == aes_package::AES_STARTING);
  assign eng_clear_o     = (current_state == aes_package::AES_IDLE);
  assign eng_enable_o    = (current_state == aes_package::AES_STARTING) |
                           (current_state == aes_package::AES_WORKING);
  assign done_o          = (current_state == aes_package::AES_FINISHED);
  assign state_o         = current_state;

endmodule

`default_nettype wire

// ==== hdl/aes_engine.sv ====
`default_nettype none

`include "aes_params.svh"

module aes_engine (
  input  wire logic                    clk,
  input  wire logic                    reset_n,
  input  wire logic                    clear_i,
  input  wire logic                    enable_i,
  input  wire logic                    start_i,
  input  wire aes_package::aes_block_t key_i,
  input  wire aes_package::aes_block_t blk_i,
  input  wire logic                    blk_valid_i,
  output logic                         blk_ready_o,
  output aes_package::aes_block_t      out_o,
  output logic                         out_valid_o,
  input  wire logic                    out_ready_i
);

  localparam int BLK_W = $bits(aes_package::aes_block_t);

  logic [3:0]              round_q;
  logic                    busy_q;
  logic                    out_valid_q;
  logic                    accept;
  aes_package::aes_block_t state_q;
  aes_package::aes_block_t rk_q;

  // Row r of the column-major state moves left by r columns
  function automatic aes_package::aes_block_t shift_rows(input aes_package::aes_block_t blk);
    logic [BLK_W-1:0] src;
    logic [BLK_W-1:0] dst;
    src = blk;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        dst[8*(r+4*c) +: 8] = src[8*(r+4*((c+r)%4)) +: 8];
      end
    end
    return dst;
  endfunction

  function automatic aes_package::aes_block_t rotate_key(input aes_package::aes_block_t key);
    logic [BLK_W-1:0] flat;
    flat = key;
    return {flat[BLK_W-9:0], flat[BLK_W-1 -: 8]};
  endfunction

  // No new block while a result is pending
  assign blk_ready_o = enable_i & ~busy_q & ~out_valid_q;
  assign accept      = blk_valid_i & blk_ready_o;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      round_q     <= '0;
      busy_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (clear_i) begin
      round_q     <= '0;
      busy_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q  <= 1'b1;
        round_q <= '0;
      end else if (busy_q) begin
        round_q <= round_q + 4'd1;
        if (round_q == 4'(`AES_ROUNDS - 1)) begin
          busy_q      <= 1'b0;
          out_valid_q <= 1'b1;
        end
      end
      if (out_valid_q && out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // One round per cycle, ShiftRows then AddRoundKey
  always_ff @(posedge clk) begin
    if (start_i) begin
      rk_q <= key_i;
    end else if (busy_q) begin
      rk_q <= rotate_key(rk_q);
    end
    if (accept) begin
      state_q <= blk_i;
    end else if (busy_q) begin
      state_q <= shift_rows(state_q) ^ rk_q;
    end
  end

  assign out_o       = state_q;
  assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

// ==== hdl/aes_sink.sv ====
`default_nettype none

`include "aes_params.svh"

module aes_sink (
  input  wire logic                    clk,
  input  wire logic                    reset_n,
  input  wire logic                    req_start_i,
  input  wire logic [`AES_ADDR_W-1:0]  base_addr_i,
  output logic                         ready_start_o,
  // Block from the engine
  input  wire aes_package::aes_block_t blk_i,
  input  wire logic                    blk_valid_i,
  output logic                         blk_ready_o,
  // Memory write port
  output logic                         wr_req_o,
  output logic [`AES_ADDR_W-1:0]       wr_addr_o,
  output logic [`AES_DATA_W-1:0]       wr_data_o,
  input  wire logic                    wr_gnt_i
);

  logic                    armed_q;
  logic                    full_q;
  logic [1:0]              cnt_q;
  logic [`AES_ADDR_W-1:0]  base_q;
  aes_package::aes_block_t blk_q;

  assign blk_ready_o = armed_q & ~full_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      armed_q <= 1'b0;
      full_q  <= 1'b0;
      cnt_q   <= '0;
    end else begin
      if (req_start_i && !armed_q) begin
        armed_q <= 1'b1;
        cnt_q   <= '0;
      end
      if (blk_valid_i && blk_ready_o) begin
        full_q <= 1'b1;
      end
      // One word per grant, disarm after the last one
      if (wr_req_o && wr_gnt_i) begin
        cnt_q <= cnt_q + 2'd1;
        if (cnt_q == 2'd3) begin
          full_q  <= 1'b0;
          armed_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_start_i && !armed_q) begin
      base_q <= base_addr_i;
    end
    if (blk_valid_i && blk_ready_o) begin
      blk_q <= blk_i;
    end
  end

  assign wr_req_o      = full_q;
  assign wr_addr_o     = base_q + `AES_ADDR_W'({cnt_q, 2'b00});
  assign wr_data_o     = blk_q[cnt_q];
  assign ready_start_o = ~armed_q;

endmodule

`default_nettype wire

// ==== hdl/aes_source.sv ====
`default_nettype none

`include "aes_params.svh"

module aes_source (
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire logic                   req_start_i,
  input  wire logic [`AES_ADDR_W-1:0] base_addr_i,
  output logic                        ready_start_o,
  // Memory read port
  output logic                        rd_req_o,
  output logic [`AES_ADDR_W-1:0]      rd_addr_o,
  input  wire logic                   rd_gnt_i,
  input  wire logic [`AES_DATA_W-1:0] rd_data_i,
  input  wire logic                   rd_valid_i,
  // Block towards the engine
  output aes_package::aes_block_t     blk_o,
  output logic                        blk_valid_o,
  input  wire logic                   blk_ready_i
);

  logic                    busy_q;
  logic                    wait_q;
  logic                    valid_q;
  logic [1:0]              cnt_q;
  logic [`AES_ADDR_W-1:0]  base_q;
  aes_package::aes_block_t blk_q;

  // One read outstanding at a time
  assign rd_req_o  = busy_q & ~wait_q & ~valid_q;
  assign rd_addr_o = base_q + `AES_ADDR_W'({cnt_q, 2'b00});

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q  <= 1'b0;
      wait_q  <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      if (req_start_i && !busy_q) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end
      if (rd_req_o && rd_gnt_i) begin
        wait_q <= 1'b1;
      end
      if (rd_valid_i && wait_q) begin
        wait_q <= 1'b0;
        cnt_q  <= cnt_q + 2'd1;
        if (cnt_q == 2'd3) begin
          valid_q <= 1'b1;
        end
      end
      // Block taken, ready for the next job
      if (valid_q && blk_ready_i) begin
        valid_q <= 1'b0;
        busy_q  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_start_i && !busy_q) begin
      base_q <= base_addr_i;
    end
    if (rd_valid_i && wait_q) begin
      blk_q[cnt_q] <= rd_data_i;
    end
  end

  assign ready_start_o = ~busy_q;
  assign blk_o         = blk_q;
  assign blk_valid_o   = valid_q;

endmodule

`default_nettype wire

// ==== hdl/aes_regfile.sv ====
`default_nettype none

`include "aes_params.svh"

module aes_regfile (
  input  wire logic                    clk,
  input  wire logic                    reset_n,
  // AXI4-Lite slave
  input  wire logic [`AES_ADDR_W-1:0]  awaddr_i,
  input  wire logic                    awvalid_i,
  output logic                         awready_o,
  input  wire logic [`AES_DATA_W-1:0]  wdata_i,
  input  wire logic [3:0]              wstrb_i,
  input  wire logic                    wvalid_i,
  output logic                         wready_o,
  output logic [1:0]                   bresp_o,
  output logic                         bvalid_o,
  input  wire logic                    bready_i,
  input  wire logic [`AES_ADDR_W-1:0]  araddr_i,
  input  wire logic                    arvalid_i,
  output logic                         arready_o,
  output logic [`AES_DATA_W-1:0]       rdata_o,
  output logic [1:0]                   rresp_o,
  output logic                         rvalid_o,
  input  wire logic                    rready_i,
  // Job control
  input  wire logic                    done_i,
  input  wire aes_package::aes_state_t fsm_state_i,
  output logic                         start_o,
  output logic [`AES_ADDR_W-1:0]       src_addr_o,
  output logic [`AES_ADDR_W-1:0]       dst_addr_o,
  output aes_package::aes_block_t      key_o
);

  logic [`AES_DATA_W-1:0]    regs_q [`AES_NB_REGS];
  logic                      wr_ready_q;
  logic                      bvalid_q;
  logic                      rd_ready_q;
  logic                      rvalid_q;
  logic [`AES_DATA_W-1:0]    rdata_q;
  logic                      start_q;
  logic                      done_q;
  logic                      busy;
  logic                      wr_fire;
  logic                      rd_fire;
  aes_package::aes_reg_idx_t wr_idx;
  aes_package::aes_reg_idx_t rd_idx;
  logic [`AES_DATA_W-1:0]    rd_word;

  // Word index from the byte address
  assign wr_idx  = aes_package::aes_reg_idx_t'(awaddr_i[4:2]);
  assign rd_idx  = aes_package::aes_reg_idx_t'(araddr_i[4:2]);
  assign wr_fire = wr_ready_q & awvalid_i & wvalid_i;
  assign rd_fire = rd_ready_q & arvalid_i;
  assign busy    = (fsm_state_i != aes_package::AES_IDLE);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      rd_ready_q <= 1'b0;
      rvalid_q   <= 1'b0;
      start_q    <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      // AW and W are taken together, one write at a time
      wr_ready_q <= awvalid_i & wvalid_i & ~wr_ready_q & ~bvalid_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      rd_ready_q <= arvalid_i & ~rd_ready_q & ~rvalid_q;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
      start_q <= wr_fire & (wr_idx == aes_package::REG_CTRL) & wstrb_i[0] & wdata_i[0];
      // Sticky done, cleared when a new job starts
      if (start_q) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  // Byte-enabled register writes
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          regs_q[wr_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    if (rd_fire) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    case (rd_idx)
      aes_package::REG_CTRL:   rd_word = '0;
      aes_package::REG_STATUS: rd_word = {{(`AES_DATA_W-2){1'b0}}, done_q, busy};
      default:                 rd_word = regs_q[rd_idx];
    endcase
  end

  assign awready_o  = wr_ready_q;
  assign wready_o   = wr_ready_q;
  assign bvalid_o   = bvalid_q;
  assign bresp_o    = 2'b00;
  assign arready_o  = rd_ready_q;
  assign rvalid_o   = rvalid_q;
  assign rdata_o    = rdata_q;
  assign rresp_o    = 2'b00;
  assign start_o    = start_q;
  assign src_addr_o = regs_q[aes_package::REG_SRC];
  assign dst_addr_o = regs_q[aes_package::REG_DST];
  assign key_o      = {regs_q[aes_package::REG_KEY3], regs_q[aes_package::REG_KEY2],
                       regs_q[aes_package::REG_KEY1], regs_q[aes_package::REG_KEY0]};

endmodule

`default_nettype wire

// ==== hdl/aes_package.sv ====
`default_nettype none

`include "aes_params.svh"

package aes_package;

  // Job control states
  typedef enum logic [1:0] {
    AES_IDLE     = 2'd0,
    AES_STARTING = 2'd1,
    AES_WORKING  = 2'd2,
    AES_FINISHED = 2'd3
  } aes_state_t;

  // One cipher block, word 0 in the low bits, byte 0 lowest
  typedef logic [3:0][`AES_DATA_W-1:0] aes_block_t;

  // Register map
  typedef enum logic [2:0] {
    REG_SRC    = 3'd0,
    REG_CTRL   = 3'd1,
    REG_STATUS = 3'd2,
    REG_DST    = 3'd3,
    REG_KEY0   = 3'd4,
    REG_KEY1   = 3'd5,
    REG_KEY2   = 3'd6,
    REG_KEY3   = 3'd7
  } aes_reg_idx_t;

endpackage

`default_nettype wire

// ==== hdl/aes_params.svh ====
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// Width of a bus and memory word
`define AES_DATA_W 32

// Byte address width for memory and AXI4-Lite
`define AES_ADDR_W 32

// Number of 32-bit registers in the register file
`define AES_NB_REGS 8

// Rounds per block, any value from 1 to 15
`define AES_ROUNDS 4

`endif
